// File: project.f
verilog/pad_pkg.sv
verilog/pad_mapper.sv
verilog/shift_port.sv
verilog/port_data_mux.sv
verilog/pad_top.sv
sim/pad_top_sva.sv
sim/pad_top_tb.sv

// File: sim/pad_top_sva.sv
/*
 * Console data bus assertions
 * Unused data lines stay low, mat lines only with the power pad on
 */
`timescale 1ns/10ps

module pad_top_sva (
	input logic                clk,
	input logic                reset_nes,
	input logic                powerpad_en,
	input pad_pkg::port_data_t joypad1_data,
	input pad_pkg::port_data_t joypad2_data
);

	////////////////////////////////
	// Port 1
	////////////////////////////////

	// Only D0 and the mic on D2
	a_p1_unused: assert property (@(posedge clk) disable iff (reset_nes)
		joypad1_data[4:3] == 2'b00 && joypad1_data[1] == 1'b0)
		else $error("joypad1_data drives an unused line: %b", joypad1_data);

	////////////////////////////////
	// Port 2
	////////////////////////////////

	a_p2_unused: assert property (@(posedge clk) disable iff (reset_nes)
		joypad2_data[2:1] == 2'b00)
		else $error("joypad2_data drives D1 or D2: %b", joypad2_data);

	// Mat lines quiet without the power pad
	a_p2_mat_off: assert property (@(posedge clk) disable iff (reset_nes)
		!powerpad_en |-> joypad2_data[4:3] == 2'b00)
		else $error("joypad2_data mat lines active with power pad off: %b", joypad2_data);

endmodule

bind pad_top pad_top_sva u_sva (
	.clk          (clk),
	.reset_nes    (reset_nes),
	.powerpad_en  (powerpad_en),
	.joypad1_data (joypad1_data),
	.joypad2_data (joypad2_data)
);

// File: sim/pad_top_tb.sv
/*
 * Controller port testbench
 * Drives joysticks, strobe and port clocks into the top level and checks
 * both console data buses against a reference model of the port shifters
 */
`timescale 1ns/10ps

module pad_top_tb;

	import pad_pkg::*;

	localparam int READS        = 24; // Bits per pad word
	localparam int EXTRA_READS  = 4;  // Reads past the end of the word
	localparam int MIC_BIT      = 9;
	localparam int IDLE_TIMEOUT = 8;

	logic       clk;
	logic       reset_nes;
	joy_t       joy_a;
	joy_t       joy_b;
	joy_t       joy_c;
	joy_t       joy_d;
	logic       joy_swap;
	logic       multitap_en;
	logic       powerpad_en;
	logic       joypad_strobe;
	logic [1:0] joypad_clock;
	port_data_t joypad1_data;
	port_data_t joypad2_data;

	// Expected shifter contents
	pad_word_t  model_pad [NUM_PORTS];
	sense_t     model_d3;
	sense_t     model_d4;
	logic       mic_masked; // D2 of port 1 checked by counting instead
	integer     seed;

	pad_top #(
		.NUM_PORTS_P (NUM_PORTS)
	) pad_top_i (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_c         (joy_c),
		.joy_d         (joy_d),
		.joy_swap      (joy_swap),
		.multitap_en   (multitap_en),
		.powerpad_en   (powerpad_en),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joypad1_data  (joypad1_data),
		.joypad2_data  (joypad2_data)
	);

	always #10 clk = ~clk;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Joystick bit feeding each console bit, bit 0 first
	function automatic btn_t console_byte(input joy_t joy);
		int   src [8] = '{4, 5, 6, 7, 3, 2, 1, 0};
		btn_t b;
		for (int i = 0; i < 8; i++) begin
			b[i] = joy[src[i]];
		end
		return b;
	endfunction

	function automatic pad_word_t ref_pad_word(input int port, input joy_t a, input joy_t b,
			input joy_t c, input joy_t d, input logic swap, input logic tap);
		joy_t       own;
		joy_t       extra;
		logic [7:0] sig;
		own   = ((port == 0) != swap) ? a : b;
		extra = (port == 0) ? c : d;
		sig   = (port == 0) ? TAP_SIG_P1 : TAP_SIG_P2;
		if (tap) begin
			return {sig, console_byte(extra), console_byte(own)};
		end
		return {16'hFFFF, console_byte(own)};
	endfunction

	function automatic sense_t ref_sense_word(input logic d4_line, input joy_t a,
			input joy_t b, input joy_t c, input joy_t d);
		logic [11:0] mat;
		mat = a[22:11] | b[22:11] | c[22:11] | d[22:11];
		if (d4_line) begin
			return {4'hF, mat[7], mat[11], mat[2], mat[3]};
		end
		return {mat[6], mat[10], mat[9], mat[5], mat[8], mat[4], mat[0], mat[1]};
	endfunction

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic fail_run(input string why);
		$display("*** TEST FAILED ***");
		$fatal(1, why);
	endtask

	task automatic check_port_data(input string name, input port_data_t got,
			input port_data_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
			fail_run("data bus mismatch");
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			fail_run("count mismatch");
		end
	endtask

	// Both buses compared every cycle outside reset
	always @(negedge clk) begin : compare_buses
		port_data_t exp1;
		port_data_t exp2;
		port_data_t got1;
		if (!reset_nes) begin
			got1 = joypad1_data;
			if (mic_masked) begin
				got1[2] = 1'b0;
			end
			exp1 = {4'b0000, model_pad[0][0]};
			exp2 = {powerpad_en & model_d4[0], powerpad_en & model_d3[0], 2'b00,
				model_pad[1][0]};
			check_port_data("joypad1_data", got1, exp1);
			check_port_data("joypad2_data", joypad2_data, exp2);
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	function automatic joy_t random_joy(input logic no_mic);
		joy_t j;
		j = joy_t'($random(seed));
		if (no_mic) begin
			j[MIC_BIT] = 1'b0; // Keep the tone off
		end
		return j;
	endfunction

	task automatic clear_model();
		model_pad[0] = '0;
		model_pad[1] = '0;
		model_d3     = '0;
		model_d4     = '0;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset_nes <= 1'b1;
		repeat (3) @(posedge clk);
		reset_nes <= 1'b0;
		clear_model();
	endtask

	task automatic wait_bus_idle();
		int n;
		n = 0;
		while ((joypad1_data !== '0 || joypad2_data !== '0) && n < IDLE_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (joypad1_data !== '0 || joypad2_data !== '0) begin
			$display("Timeout: data buses did not read zero after reset");
			fail_run("reset timeout");
		end
	endtask

	task automatic load_random_joysticks();
		@(posedge clk);
		joy_a <= random_joy(1'b1);
		joy_b <= random_joy(1'b1);
		joy_c <= random_joy(1'b0);
		joy_d <= random_joy(1'b0);
	endtask

	task automatic strobe_ports();
		@(posedge clk);
		joypad_strobe <= 1'b1;
		@(posedge clk);
		joypad_strobe <= 1'b0;
		// DUT loads at this edge
		for (int p = 0; p < NUM_PORTS; p++) begin
			model_pad[p] = ref_pad_word(p, joy_a, joy_b, joy_c, joy_d, joy_swap, multitap_en);
		end
		model_d3 = ref_sense_word(1'b0, joy_a, joy_b, joy_c, joy_d);
		model_d4 = ref_sense_word(1'b1, joy_a, joy_b, joy_c, joy_d);
	endtask

	task automatic pulse_clock(input logic [1:0] mask);
		@(posedge clk);
		joypad_clock <= mask;
		@(posedge clk);
		joypad_clock <= 2'b00;
		@(posedge clk); // Falling clock seen here
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (mask[p]) begin
				model_pad[p] = {1'b0, model_pad[p][23:1]};
			end
		end
		if (mask[1]) begin
			model_d3 = {1'b1, model_d3[7:1]};
			model_d4 = {1'b1, model_d4[7:1]};
		end
	endtask

	task automatic read_ports(input logic [1:0] mask);
		repeat (READS + EXTRA_READS) pulse_clock(mask);
	endtask

	task automatic count_mic_high(output int high);
		high = 0;
		repeat (MIC_WRAP + 1) begin
			@(negedge clk);
			if (joypad1_data[2] === 1'b1) begin
				high++;
			end
		end
	endtask

	initial begin
		int high;
		clk           = 1'b0;
		reset_nes     = 1'b1;
		joy_a         = '0;
		joy_b         = '0;
		joy_c         = '0;
		joy_d         = '0;
		joy_swap      = 1'b0;
		multitap_en   = 1'b0;
		powerpad_en   = 1'b0;
		joypad_strobe = 1'b0;
		joypad_clock  = 2'b00;
		mic_masked    = 1'b0;
		seed          = 88557;
		clear_model();
		repeat (3) @(posedge clk);
		reset_nes <= 1'b0;

		// Idle buses after reset
		wait_bus_idle();
		repeat (4) @(posedge clk);

		// Plain pads on both ports
		for (int r = 0; r < 4; r++) begin
			load_random_joysticks();
			strobe_ports();
			read_ports(2'b11);
		end

		// Swapped ports, read one at a time
		@(posedge clk);
		joy_swap <= 1'b1;
		for (int r = 0; r < 3; r++) begin
			load_random_joysticks();
			strobe_ports();
			read_ports(2'b01);
			read_ports(2'b10);
		end

		// Four player adapter
		@(posedge clk);
		joy_swap    <= 1'b0;
		multitap_en <= 1'b1;
		for (int r = 0; r < 3; r++) begin
			load_random_joysticks();
			strobe_ports();
			read_ports(2'b11);
		end

		// Floor mat on port 2
		@(posedge clk);
		multitap_en <= 1'b0;
		powerpad_en <= 1'b1;
		for (int r = 0; r < 4; r++) begin
			load_random_joysticks();
			strobe_ports();
			read_ports((r % 2 == 0) ? 2'b10 : 2'b11);
		end

		// Mic tone from a fresh counter
		@(posedge clk);
		powerpad_en <= 1'b0;
		joy_a       <= joy_t'(1) << MIC_BIT;
		joy_b       <= '0;
		joy_c       <= '0;
		joy_d       <= '0;
		mic_masked = 1'b1;
		apply_reset();
		count_mic_high(high);
		check_count("mic tone cycles, button held", high, MIC_ON_COUNT);
		@(posedge clk);
		joy_a <= '0;
		mic_masked = 1'b0;
		count_mic_high(high);
		check_count("mic tone cycles, button released", high, 0);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: verilog/pad_mapper.sv
/*
 * Pad mapper
 * Turns the host joysticks into the load words of both pad ports,
 * with swap and multitap, and the two power pad sensor words
 */
`timescale 1ns/10ps

module pad_mapper (
	input  pad_pkg::joy_t      joy_a,
	input  pad_pkg::joy_t      joy_b,
	input  pad_pkg::joy_t      joy_c,
	input  pad_pkg::joy_t      joy_d,
	input  logic               joy_swap,
	input  logic               multitap_en,
	output pad_pkg::pad_word_t pad_load [pad_pkg::NUM_PORTS],
	output pad_pkg::sense_t    sense_d3_load,
	output pad_pkg::sense_t    sense_d4_load
);

	import pad_pkg::*;

	// Every index of key_idx_t gets a slot, spare slots read one
	localparam int KEY_SLOTS = 2 ** $bits(key_idx_t);

	//////////////////////////////
	// Button reorder
	//////////////////////////////

	// Console order is Right Left Down Up Start Select B A from bit 7
	function automatic btn_t to_console(input joy_t joy);
		return {joy[0], joy[1], joy[2], joy[3], joy[7], joy[6], joy[5], joy[4]};
	endfunction

	btn_t btn_a;
	btn_t btn_b;
	btn_t btn_c;
	btn_t btn_d;
	btn_t port1_btn;
	btn_t port2_btn;

	assign btn_a = to_console(joy_a);
	assign btn_b = to_console(joy_b);
	assign btn_c = to_console(joy_c);
	assign btn_d = to_console(joy_d);

	assign port1_btn = joy_swap ? btn_b : btn_a;
	assign port2_btn = joy_swap ? btn_a : btn_b;

	//////////////////////////////
	// Port load words
	//////////////////////////////

	// Without the tap the upper 16 reads are all ones
	assign pad_load[0] = multitap_en ? {TAP_SIG_P1, btn_c, port1_btn}
	                                 : {16'hFFFF, port1_btn};
	assign pad_load[1] = multitap_en ? {TAP_SIG_P2, btn_d, port2_btn}
	                                 : {16'hFFFF, port2_btn};

	//////////////////////////////
	// Power pad
	//////////////////////////////

	logic [POWERPAD_KEYS-1:0] mat_keys;
	logic [KEY_SLOTS-1:0]     key_slots;

	// Any joystick may press a mat key
	assign mat_keys = joy_a[JOY_BITS-1 -: POWERPAD_KEYS]
	                | joy_b[JOY_BITS-1 -: POWERPAD_KEYS]
	                | joy_c[JOY_BITS-1 -: POWERPAD_KEYS]
	                | joy_d[JOY_BITS-1 -: POWERPAD_KEYS];

	assign key_slots = {{(KEY_SLOTS - POWERPAD_KEYS){1'b1}}, mat_keys};

	function automatic sense_t order_keys(
		input logic [KEY_SLOTS-1:0] slots,
		input sense_order_t         order
	);
		sense_t word;
		for (int i = 0; i < $bits(sense_t); i++) begin
			word[i] = slots[order[i]];
		end
		return word;
	endfunction

	assign sense_d3_load = order_keys(key_slots, SENSE_D3_ORDER);
	assign sense_d4_load = order_keys(key_slots, SENSE_D4_ORDER);

endmodule

// File: verilog/pad_pkg.sv
/*
 * Controller port definitions
 * Widths, word types and constants shared by the pad mapper, the port
 * shifters and the console data bus logic
 */
package pad_pkg;

	////////////////////////////////
	// Host side
	////////////////////////////////

	localparam int JOY_BITS      = 23;  // Bits 11..22 carry the mat keys
	localparam int POWERPAD_KEYS = 12;

	typedef logic [JOY_BITS-1:0] joy_t;

	////////////////////////////////
	// Console side
	////////////////////////////////

	localparam int BTN_BITS  = 8;
	localparam int NUM_PORTS = 2;

	typedef logic [BTN_BITS-1:0] btn_t;
	typedef logic [23:0]         pad_word_t;  // Buttons low, tap byte above
	typedef logic [7:0]          sense_t;     // One power pad sensor line
	typedef logic [4:0]          port_data_t; // D0..D4 of one port

	// Multitap signature bytes
	localparam logic [7:0] TAP_SIG_P1 = 8'h08;
	localparam logic [7:0] TAP_SIG_P2 = 8'h04;

	// Microphone tone counter
	localparam int MIC_ON_COUNT = 215;
	localparam int MIC_WRAP     = 250;

	////////////////////////////////
	// Power pad readout order
	////////////////////////////////

	// Mat key index per sensor bit, bit 7 first
	typedef logic [3:0] key_idx_t;
	typedef key_idx_t   sense_order_t [7:0];

	// Index past the last mat key, always reads as one
	localparam key_idx_t KEY_ONE = 4'd15;

	localparam sense_order_t SENSE_D3_ORDER = '{
		4'd6, 4'd10, 4'd9, 4'd5, 4'd8, 4'd4, 4'd0, 4'd1
	};

	localparam sense_order_t SENSE_D4_ORDER = '{
		KEY_ONE, KEY_ONE, KEY_ONE, KEY_ONE, 4'd7, 4'd11, 4'd2, 4'd3
	};

endpackage

// File: verilog/pad_top.sv
/*
 * Controller port top level
 * Joystick mapper, one pad shifter per console port, the power pad
 * sensor shifters on port 2 and the console data bus multiplexer
 */
`timescale 1ns/10ps

module pad_top #(
	parameter int NUM_PORTS_P = pad_pkg::NUM_PORTS
) (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  pad_pkg::joy_t          joy_a,
	input  pad_pkg::joy_t          joy_b,
	input  pad_pkg::joy_t          joy_c,
	input  pad_pkg::joy_t          joy_d,
	input  logic                   joy_swap,
	input  logic                   multitap_en,
	input  logic                   powerpad_en,
	input  logic                   joypad_strobe,
	input  logic [NUM_PORTS_P-1:0] joypad_clock,
	output pad_pkg::port_data_t    joypad1_data,
	output pad_pkg::port_data_t    joypad2_data
);

	import pad_pkg::*;

	localparam int MIC_JOY_BIT = 9; // Mic button on the host joystick

	pad_word_t              pad_load [NUM_PORTS_P];
	sense_t                 sense_d3_load;
	sense_t                 sense_d4_load;
	logic [NUM_PORTS_P-1:0] pad_bit;
	logic                   sense_d3_bit;
	logic                   sense_d4_bit;
	logic                   mic_button;

	assign mic_button = joy_a[MIC_JOY_BIT] | joy_b[MIC_JOY_BIT];

	//////////////////////////////
	// Load words
	//////////////////////////////

	pad_mapper u_mapper (
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_c         (joy_c),
		.joy_d         (joy_d),
		.joy_swap      (joy_swap),
		.multitap_en   (multitap_en),
		.pad_load      (pad_load),
		.sense_d3_load (sense_d3_load),
		.sense_d4_load (sense_d4_load)
	);

	//////////////////////////////
	// Shifters
	//////////////////////////////

	for (genvar i = 0; i < NUM_PORTS_P; i++) begin : g_pad_port
		shift_port #(
			.payload_t (pad_word_t),
			.FILL      (1'b0)
		) u_pad_shift (
			.clk        (clk),
			.reset_nes  (reset_nes),
			.load       (joypad_strobe),
			.port_clock (joypad_clock[i]),
			.load_word  (pad_load[i]),
			.out_bit    (pad_bit[i])
		);
	end

	// Mat sensors read on port 2, ones after the last key
	shift_port #(
		.payload_t (sense_t),
		.FILL      (1'b1)
	) u_d3_shift (
		.clk        (clk),
		.reset_nes  (reset_nes),
		.load       (joypad_strobe),
		.port_clock (joypad_clock[1]),
		.load_word  (sense_d3_load),
		.out_bit    (sense_d3_bit)
	);

	shift_port #(
		.payload_t (sense_t),
		.FILL      (1'b1)
	) u_d4_shift (
		.clk        (clk),
		.reset_nes  (reset_nes),
		.load       (joypad_strobe),
		.port_clock (joypad_clock[1]),
		.load_word  (sense_d4_load),
		.out_bit    (sense_d4_bit)
	);

	//////////////////////////////
	// Console buses
	//////////////////////////////

	port_data_mux u_data_mux (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.pad_bit      (pad_bit),
		.sense_d3_bit (sense_d3_bit),
		.sense_d4_bit (sense_d4_bit),
		.powerpad_en  (powerpad_en),
		.mic_button   (mic_button),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data)
	);

endmodule

// File: verilog/port_data_mux.sv
/*
 * Port data multiplexer
 * Builds both console data buses and generates the microphone tone
 */
`timescale 1ns/10ps

module port_data_mux (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  logic [pad_pkg::NUM_PORTS-1:0]  pad_bit,
	input  logic                           sense_d3_bit,
	input  logic                           sense_d4_bit,
	input  logic                           powerpad_en,
	input  logic                           mic_button,
	output pad_pkg::port_data_t            joypad1_data,
	output pad_pkg::port_data_t            joypad2_data
);

	import pad_pkg::*;

	localparam int CNT_W = $clog2(MIC_WRAP + 1);

	//////////////////////////////
	// Microphone tone
	//////////////////////////////

	logic [CNT_W-1:0] mic_cnt;
	logic             mic_tone;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			mic_cnt <= '0;
		end else if (mic_cnt == CNT_W'(MIC_WRAP)) begin
			mic_cnt <= '0;
		end else begin
			mic_cnt <= mic_cnt + 1'b1;
		end
	end

	// Duty of the square wave the console samples
	assign mic_tone = (mic_cnt < CNT_W'(MIC_ON_COUNT)) && mic_button;

	//////////////////////////////
	// Data buses
	//////////////////////////////

	// Port 1 has the mic on D2
	assign joypad1_data = {2'b00, mic_tone, 1'b0, pad_bit[0]};

	always_comb begin
		joypad2_data    = '0;
		joypad2_data[0] = pad_bit[1];
		// Mat sensors ride on D3 and D4
		if (powerpad_en) begin
			joypad2_data[4] = sense_d4_bit;
			joypad2_data[3] = sense_d3_bit;
		end
	end

endmodule

// File: verilog/shift_port.sv
/*
 * Console port shifter
 * Parallel load on strobe, shifts right on each falling port clock
 */
`timescale 1ns/10ps

module shift_port #(
	parameter type  payload_t = logic [7:0],
	parameter logic FILL      = 1'b0
) (
	input  logic     clk,
	input  logic     reset_nes,
	input  logic     load,
	input  logic     port_clock,
	input  payload_t load_word,
	output logic     out_bit
);

	localparam int W = $bits(payload_t);

	logic [W-1:0] shift_reg;
	logic         last_clock; // Port clock seen at the previous edge
	logic         clock_fall;

	// High at the first edge that samples the port clock low again
	assign clock_fall = last_clock & ~port_clock;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			last_clock <= 1'b0;
		end else begin
			last_clock <= port_clock;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shift_reg <= '0;
		end else if (clock_fall) begin
			// A read in progress beats a new strobe
			shift_reg <= {FILL, shift_reg[W-1:1]};
		end else if (load) begin
			shift_reg <= load_word;
		end
	end

	assign out_bit = shift_reg[0]; // Console sees the low bit first

endmodule
